// File: Makefile
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f sim.f --top-module bpu_tb

obj_dir/Vbpu_tb: sim.f src/*.sv dv/*.sv dv/*.svh
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module bpu_tb

sim: obj_dir/Vbpu_tb
	./obj_dir/Vbpu_tb > sim.log 2>&1; cat sim.log
	@! grep -q ">>> FAIL" sim.log
	@grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/bpu_tb_tests.svh
task automatic reset_defaults();
    int                   errs;
    bpu_pkg::prediction_t got;
    errs = errors;
    lookup(32'h0000_1000, NOP_INST, got);
    check_addr("pred_o.target", got.target, 32'h0000_1004);
    lookup(32'h0000_1010, branch_inst(13'h040), got);  // weakly not taken
    check_addr("pred_o.target", got.target, 32'h0000_1014);
    lookup(RET_PC, RET_INST, got);  // empty stack, no btb entry
    check_addr("pred_o.target", got.target, RET_PC + 32'd4);
    report_test("after reset", errs);
endtask

task automatic bimodal_training();
    int                   errs;
    bpu_pkg::prediction_t got;
    bpu_pkg::addr_t       pc;
    bpu_pkg::addr_t       tgt;
    bpu_pkg::inst_t       inst;
    errs = errors;
    pc   = $random(seed) & 32'hffff_fffc;
    tgt  = pc + 32'h0000_0100;  // differs from the b-immediate target
    inst = branch_inst(13'h040);
    send_update(pc, inst, 1'b1, tgt);
    lookup(pc, inst, got);
    check_addr("pred_o.target", got.target, tgt);
    send_update(pc, inst, 1'b0, tgt);
    send_update(pc, inst, 1'b0, tgt);
    lookup(pc, inst, got);
    check_addr("pred_o.target", got.target, pc + 32'd4);
    // counter already at 0, one taken only reaches 1
    send_update(pc, inst, 1'b0, tgt);
    send_update(pc, inst, 1'b1, tgt);
    lookup(pc, inst, got);
    check_addr("pred_o.target", got.target, pc + 32'd4);
    report_test("bimodal training", errs);
endtask

task automatic jal_targets();
    int                   errs;
    bpu_pkg::prediction_t got;
    bpu_pkg::inst_t       inst;
    errs = errors;
    inst = jal_inst(21'h1f_ff00);  // offset -256
    lookup(32'h0000_2040, inst, got);
    check_addr("pred_o.target", got.target, 32'h0000_1f40);
    send_update(32'h0000_2440, inst, 1'b1, 32'h0000_9000);  // same index, other tag
    lookup(32'h0000_2040, inst, got);
    check_addr("pred_o.target", got.target, 32'h0000_1f40);
    send_update(32'h0000_2040, inst, 1'b1, 32'h0000_a000);
    lookup(32'h0000_2040, inst, got);
    check_addr("pred_o.target", got.target, 32'h0000_a000);
    report_test("jal", errs);
endtask

task automatic stack_push_pop();
    int                   errs;
    bpu_pkg::prediction_t got;
    errs = errors;
    push_call(32'h0000_3004, 1'b0);
    push_call(32'h0000_3104, 1'b0);
    lookup(RET_PC, RET_INST, got);
    check_addr("pred_o.target", got.target, 32'h0000_3104);
    send_update(RET_PC, RET_INST, 1'b1, 32'h0000_3104);  // resolved return pops
    lookup(RET_PC, RET_INST, got);
    check_addr("pred_o.target", got.target, 32'h0000_3004);
    push_call(32'h0000_3304, 1'b1);
    lookup(RET_PC, RET_INST, got);
    check_addr("pred_o.target", got.target, 32'h0000_3004);
    report_test("stack", errs);
endtask

task automatic flush_and_depth();
    int                   errs;
    bpu_pkg::prediction_t got;
    errs = errors;
    push_call(32'h0000_4004, 1'b0);
    push_call(32'h0000_4104, 1'b0);
    flush_stack();
    lookup(RET_PC, RET_INST, got);
    check_addr("pred_o.target", got.target, 32'h0000_4004);
    send_update(RET_PC, RET_INST, 1'b1, 32'h0000_4004);  // sp now below the old checkpoint
    lookup(RET_PC, RET_INST, got);
    check_addr("pred_o.target", got.target, 32'h0000_3004);
    flush_stack();  // checkpoint already used
    lookup(RET_PC, RET_INST, got);
    check_addr("pred_o.target", got.target, 32'h0000_3004);
    while (m_sp > 0) begin
        send_update(RET_PC, RET_INST, 1'b1, RET_PC + 32'd4);
    end
    for (int i = 1; i <= RAS_DEPTH + 1; i++) begin
        push_call(32'h0005_0000 + 32'(i) * 32'h10, 1'b0);
    end
    lookup(RET_PC, RET_INST, got);
    check_addr("pred_o.target", got.target, 32'h0005_0000 + 32'(RAS_DEPTH) * 32'h10);
    report_test("flush and depth", errs);
endtask

// File: dv/bpu_tb.sv
module bpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 8;
    localparam int BHT_ENTRIES    = 512;
    localparam int BTB_ENTRIES    = 256;
    localparam int RAS_DEPTH      = 32;
    localparam int TIMEOUT_CYCLES = 2000;  // tests need roughly 200 cycles

    localparam bpu_pkg::inst_t NOP_INST = 32'h0000_0013;  // addi x0, x0, 0
    localparam bpu_pkg::inst_t RET_INST = 32'h0000_8067;  // jalr x0, 0(x1)
    localparam bpu_pkg::addr_t RET_PC   = 32'h0000_3200;

    typedef logic [$clog2(RAS_DEPTH)-1:0] slot_t;

    logic                 clk;
    logic                 rst;
    bpu_pkg::fetch_t      fetch_i;
    bpu_pkg::ex_update_t  ex_upd_i;
    logic                 id_push_i;
    bpu_pkg::addr_t       id_push_data_i;
    logic                 stall_i;
    logic                 flush_i;
    bpu_pkg::prediction_t pred_o;

    // reference model, indexed as pc[9:1] and pc[9:2]
    bpu_pkg::ctr_t          m_ctr    [BHT_ENTRIES];
    logic [BTB_ENTRIES-1:0] m_valid;
    logic [21:0]            m_tag    [BTB_ENTRIES];
    bpu_pkg::addr_t         m_target [BTB_ENTRIES];
    bpu_pkg::addr_t         m_stack  [RAS_DEPTH];
    int                     m_sp;
    int                     m_ckpt;
    logic                   m_armed;

    int     errors;
    int     tests_run;
    int     tests_failed;
    int     cycles;
    integer seed;

    bpu_top #(
        .BHT_ENTRIES(BHT_ENTRIES),
        .BTB_ENTRIES(BTB_ENTRIES),
        .RAS_DEPTH  (RAS_DEPTH)
    ) i_bpu_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic bpu_pkg::inst_t branch_inst(input logic [12:0] off);
        return {off[12], off[10:5], 10'd0, 3'b000, off[4:1], off[11], bpu_pkg::OPC_BRANCH};
    endfunction

    function automatic bpu_pkg::inst_t jal_inst(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, bpu_pkg::OPC_JAL};  // rd x1
    endfunction

    function automatic bpu_pkg::prediction_t expect_pred(input bpu_pkg::addr_t pc,
                                                         input bpu_pkg::inst_t inst);
        bpu_pkg::prediction_t p;
        logic                 hit;
        logic signed [31:0]   b_off;
        logic signed [31:0]   j_off;
        hit   = m_valid[pc[9:2]] && m_tag[pc[9:2]] == pc[31:10];
        b_off = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
        j_off = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
        p     = '{is_ctrl: 1'b1, taken: 1'b0, target: pc + 32'd4};
        if (inst[6:0] == bpu_pkg::OPC_JALR && inst[11:7] == 5'd0 && inst[19:15] == 5'd1 &&
            inst[31:20] == 12'd0) begin
            if (m_sp > 0) begin
                p.taken  = 1'b1;
                p.target = m_stack[slot_t'(m_sp - 1)];
            end else if (hit) begin
                p.taken  = 1'b1;
                p.target = m_target[pc[9:2]];
            end
        end else if (inst[6:0] == bpu_pkg::OPC_JAL) begin
            p.taken  = 1'b1;
            p.target = hit ? m_target[pc[9:2]] : pc + j_off;
        end else if (inst[6:0] == bpu_pkg::OPC_BRANCH || inst[6:0] == bpu_pkg::OPC_JALR) begin
            p.taken = m_ctr[pc[9:1]][1];
            if (p.taken && hit) begin
                p.target = m_target[pc[9:2]];
            end else if (p.taken && inst[6:0] == bpu_pkg::OPC_BRANCH) begin
                p.target = pc + b_off;
            end
        end else begin
            p.is_ctrl = 1'b0;
        end
        return p;
    endfunction

    task automatic train_model(input bpu_pkg::ex_update_t upd);
        bpu_pkg::ctr_t c;
        c = m_ctr[upd.pc[9:1]];
        if (upd.taken && c != 2'd3) begin
            c = c + 2'd1;
        end else if (!upd.taken && c != 2'd0) begin
            c = c - 2'd1;
        end
        m_ctr[upd.pc[9:1]] = c;
        if (upd.taken) begin
            m_valid[upd.pc[9:2]]  = 1'b1;
            m_tag[upd.pc[9:2]]    = upd.pc[31:10];
            m_target[upd.pc[9:2]] = upd.target;
        end
    endtask

    // stack rules in priority order
    task automatic step_stack(input logic push, input logic pop, input bpu_pkg::addr_t data,
                              input logic flush);
        if (flush && m_armed) begin
            m_sp    = m_ckpt;
            m_armed = 1'b0;
        end else if (push && pop) begin
            if (m_sp > 0) begin
                m_stack[slot_t'(m_sp - 1)] = data;
            end
        end else if (push) begin
            m_ckpt  = m_sp;
            m_armed = 1'b1;
            if (m_sp < RAS_DEPTH) begin
                m_stack[slot_t'(m_sp)] = data;
                m_sp++;
            end
        end else if (pop && m_sp > 0) begin
            m_sp--;
        end
    endtask

    task automatic check_pred(input string name, input bpu_pkg::prediction_t got,
                              input bpu_pkg::prediction_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %b/%b/%h expected %b/%b/%h", $time, name,
                     got.is_ctrl, got.taken, got.target, exp.is_ctrl, exp.taken, exp.target);
        end
    endtask

    task automatic check_addr(input string name, input bpu_pkg::addr_t got,
                              input bpu_pkg::addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic lookup(input bpu_pkg::addr_t pc, input bpu_pkg::inst_t inst,
                          output bpu_pkg::prediction_t got);
        @(negedge clk);
        fetch_i.pc   = pc;
        fetch_i.inst = inst;
        #(CLK_PERIOD / 4);  // well clear of both edges
        got = pred_o;
        check_pred("pred_o", got, expect_pred(pc, inst));
    endtask

    task automatic send_update(input bpu_pkg::addr_t pc, input bpu_pkg::inst_t inst,
                               input logic taken, input bpu_pkg::addr_t target);
        @(negedge clk);
        ex_upd_i = '{valid: 1'b1, taken: taken, pc: pc, target: target, inst: inst};
        train_model(ex_upd_i);
        step_stack(1'b0, taken && inst[6:0] == bpu_pkg::OPC_JALR && inst[19:15] == 5'd1,
                   '0, 1'b0);
        @(negedge clk);
        ex_upd_i = '0;
    endtask

    task automatic push_call(input bpu_pkg::addr_t data, input logic stalled);
        @(negedge clk);
        id_push_i      = 1'b1;
        id_push_data_i = data;
        stall_i        = stalled;
        step_stack(!stalled, 1'b0, data, 1'b0);
        @(negedge clk);
        id_push_i = 1'b0;
        stall_i   = 1'b0;
    endtask

    task automatic flush_stack();
        @(negedge clk);
        flush_i = 1'b1;
        step_stack(1'b0, 1'b0, '0, 1'b1);
        @(negedge clk);
        flush_i = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors > errs_before) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    `include "bpu_tb_tests.svh"

    initial begin
        seed           = 32'h62a4_b1e9;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        cycles         = 0;
        rst            = 1'b1;
        fetch_i        = '0;
        ex_upd_i       = '0;
        id_push_i      = 1'b0;
        id_push_data_i = '0;
        stall_i        = 1'b0;
        flush_i        = 1'b0;
        m_ctr          = '{default: bpu_pkg::CTR_RESET};
        m_valid        = '0;
        m_sp           = 0;
        m_ckpt         = 0;
        m_armed        = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_defaults();
        bimodal_training();
        jal_targets();
        stack_push_pop();
        flush_and_depth();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+dv
src/bpu_pkg.sv
src/bpu_ctrl.sv
src/bimodal_bht.sv
src/btb.sv
src/ras.sv
src/bpu_top.sv
dv/bpu_tb.sv

// File: src/bimodal_bht.sv
module bimodal_bht #(
    parameter int BHT_ENTRIES = 512
) (
    input  logic                clk,
    input  logic                rst,
    input  bpu_pkg::addr_t      lookup_pc_i,
    input  bpu_pkg::ex_update_t ex_upd_i,
    output bpu_pkg::ctr_t       ctr_o
);

    localparam int IDX_W = $clog2(BHT_ENTRIES);

    typedef logic [IDX_W-1:0] idx_t;

    bpu_pkg::ctr_t ctr_q [BHT_ENTRIES];
    idx_t          rd_idx;
    idx_t          wr_idx;
    bpu_pkg::ctr_t wr_old;

    // halfword aligned index, bit 0 dropped
    assign rd_idx = lookup_pc_i[IDX_W:1];
    assign wr_idx = ex_upd_i.pc[IDX_W:1];
    assign wr_old = ctr_q[wr_idx];

    assign ctr_o = ctr_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                ctr_q[i] <= bpu_pkg::CTR_RESET;
            end
        end else if (ex_upd_i.valid) begin
            if (ex_upd_i.taken) begin
                if (wr_old != bpu_pkg::CTR_MAX) begin
                    ctr_q[wr_idx] <= wr_old + 2'd1;
                end
            end else if (wr_old != bpu_pkg::CTR_MIN) begin
                ctr_q[wr_idx] <= wr_old - 2'd1;  // saturates at 0
            end
        end
    end

endmodule

// File: src/bpu_ctrl.sv
module bpu_ctrl (
    input  bpu_pkg::fetch_t      fetch_i,
    input  bpu_pkg::ex_update_t  ex_upd_i,
    input  logic                 id_push_i,
    input  logic                 stall_i,
    input  bpu_pkg::addr_t       id_push_data_i,
    input  bpu_pkg::ctr_t        ctr_i,
    input  bpu_pkg::target_rd_t  btb_rd_i,
    input  bpu_pkg::target_rd_t  ras_top_i,
    output bpu_pkg::addr_t       lookup_pc_o,
    output bpu_pkg::ras_cmd_t    ras_cmd_o,
    output bpu_pkg::prediction_t pred_o
);

    function automatic bpu_pkg::inst_class_e classify(input bpu_pkg::inst_t inst);
        bpu_pkg::inst_class_e cls;
        cls = bpu_pkg::CLS_OTHER;
        case (inst[6:0])
            bpu_pkg::OPC_BRANCH: cls = bpu_pkg::CLS_BRANCH;
            bpu_pkg::OPC_JAL:    cls = bpu_pkg::CLS_JAL;
            bpu_pkg::OPC_JALR: begin
                // plain return: rd x0, rs1 x1, zero offset
                if (inst[11:7] == bpu_pkg::REG_X0 && inst[19:15] == bpu_pkg::REG_RA &&
                    inst[31:20] == 12'd0) begin
                    cls = bpu_pkg::CLS_RET;
                end else begin
                    cls = bpu_pkg::CLS_JALR;
                end
            end
            default: cls = bpu_pkg::CLS_OTHER;
        endcase
        return cls;
    endfunction

    bpu_pkg::inst_class_e fetch_cls;
    bpu_pkg::inst_class_e ex_cls;
    bpu_pkg::inst_t       inst;
    bpu_pkg::addr_t       pc;
    bpu_pkg::addr_t       pc_plus4;
    bpu_pkg::addr_t       b_imm;
    bpu_pkg::addr_t       j_imm;
    logic                 ex_links_ra;  // ex jalr reads x1

    assign inst      = fetch_i.inst;
    assign pc        = fetch_i.pc;
    assign pc_plus4  = pc + bpu_pkg::addr_t'(4);
    assign fetch_cls = classify(inst);
    assign ex_cls    = classify(ex_upd_i.inst);

    // sign extended offsets
    assign b_imm = {{(bpu_pkg::XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign j_imm = {{(bpu_pkg::XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign lookup_pc_o = pc;  // same index source for bht and btb

    assign ex_links_ra = (ex_cls == bpu_pkg::CLS_JALR || ex_cls == bpu_pkg::CLS_RET) &&
                         ex_upd_i.inst[19:15] == bpu_pkg::REG_RA;

    assign ras_cmd_o.push      = id_push_i && !stall_i;
    assign ras_cmd_o.pop       = ex_upd_i.valid && ex_upd_i.taken && ex_links_ra;
    assign ras_cmd_o.push_data = id_push_data_i;

    always_comb begin
        pred_o.is_ctrl = 1'b0;
        pred_o.taken   = 1'b0;
        pred_o.target  = pc_plus4;
        case (fetch_cls)
            bpu_pkg::CLS_RET: begin
                pred_o.is_ctrl = 1'b1;
                if (ras_top_i.hit) begin
                    pred_o.taken  = 1'b1;
                    pred_o.target = ras_top_i.target;
                end else if (btb_rd_i.hit) begin  // empty stack, fall back to btb
                    pred_o.taken  = 1'b1;
                    pred_o.target = btb_rd_i.target;
                end
            end
            bpu_pkg::CLS_JAL: begin
                pred_o.is_ctrl = 1'b1;
                pred_o.taken   = 1'b1;
                pred_o.target  = btb_rd_i.hit ? btb_rd_i.target : pc + j_imm;
            end
            bpu_pkg::CLS_BRANCH, bpu_pkg::CLS_JALR: begin
                pred_o.is_ctrl = 1'b1;
                pred_o.taken   = ctr_i[1];
                if (ctr_i[1]) begin
                    if (btb_rd_i.hit) begin
                        pred_o.target = btb_rd_i.target;
                    end else if (fetch_cls == bpu_pkg::CLS_BRANCH) begin
                        pred_o.target = pc + b_imm;
                    end
                end
            end
            default: ;
        endcase
    end

    // counter and btb state must never steer a non-control fetch
    always_comb begin
        assert final (inst[6:0] inside {bpu_pkg::OPC_BRANCH, bpu_pkg::OPC_JAL,
                                        bpu_pkg::OPC_JALR} ||
                      !(pred_o.is_ctrl || pred_o.taken))
            else $error("taken prediction for non-control instruction");
    end

endmodule

// File: src/bpu_pkg.sv
package bpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;  // pc or target
    typedef logic [31:0]     inst_t;  // raw instruction word
    typedef logic [1:0]      ctr_t;   // msb set means predict taken
    typedef logic [4:0]      reg_idx_t;

    localparam ctr_t CTR_RESET = 2'd1;  // weakly not taken
    localparam ctr_t CTR_MAX   = 2'd3;
    localparam ctr_t CTR_MIN   = 2'd0;

    // opcode field, inst[6:0]
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam reg_idx_t REG_X0 = 5'd0;
    localparam reg_idx_t REG_RA = 5'd1;  // link register x1

    typedef enum logic [2:0] {
        CLS_OTHER  = 3'd0,
        CLS_BRANCH = 3'd1,
        CLS_JAL    = 3'd2,
        CLS_JALR   = 3'd3,
        CLS_RET    = 3'd4   // jalr x0, 0(x1)
    } inst_class_e;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_t;

    // resolved branch from execute
    typedef struct packed {
        logic  valid;
        logic  taken;
        addr_t pc;
        addr_t target;
        inst_t inst;
    } ex_update_t;

    typedef struct packed {
        logic  is_ctrl;
        logic  taken;
        addr_t target;
    } prediction_t;

    // shared by the btb lookup and the ras top
    typedef struct packed {
        logic  hit;
        addr_t target;
    } target_rd_t;

    typedef struct packed {
        logic  push;
        logic  pop;
        addr_t push_data;
    } ras_cmd_t;

endpackage

// File: src/bpu_top.sv
module bpu_top #(
    parameter int BHT_ENTRIES = 512,
    parameter int BTB_ENTRIES = 256,
    parameter int RAS_DEPTH   = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  bpu_pkg::fetch_t      fetch_i,
    input  bpu_pkg::ex_update_t  ex_upd_i,
    input  logic                 id_push_i,
    input  bpu_pkg::addr_t       id_push_data_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    output bpu_pkg::prediction_t pred_o
);

    bpu_pkg::addr_t      lookup_pc;
    bpu_pkg::ctr_t       ctr;
    bpu_pkg::target_rd_t btb_rd;
    bpu_pkg::target_rd_t ras_top;
    bpu_pkg::ras_cmd_t   ras_cmd;

    bpu_ctrl i_ctrl (
        .fetch_i        (fetch_i),
        .ex_upd_i       (ex_upd_i),
        .id_push_i      (id_push_i),
        .stall_i        (stall_i),
        .id_push_data_i (id_push_data_i),
        .ctr_i          (ctr),
        .btb_rd_i       (btb_rd),
        .ras_top_i      (ras_top),
        .lookup_pc_o    (lookup_pc),
        .ras_cmd_o      (ras_cmd),
        .pred_o         (pred_o)
    );

    bimodal_bht #(.BHT_ENTRIES(BHT_ENTRIES)) i_bht (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (lookup_pc),
        .ex_upd_i    (ex_upd_i),
        .ctr_o       (ctr)
    );

    btb #(.BTB_ENTRIES(BTB_ENTRIES)) i_btb (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (lookup_pc),
        .ex_upd_i    (ex_upd_i),
        .rd_o        (btb_rd)
    );

    ras #(.RAS_DEPTH(RAS_DEPTH)) i_ras (
        .clk     (clk),
        .rst     (rst),
        .cmd_i   (ras_cmd),
        .flush_i (flush_i),
        .top_o   (ras_top)
    );

endmodule

// File: src/btb.sv
module btb #(
    parameter int BTB_ENTRIES = 256
) (
    input  logic                 clk,
    input  logic                 rst,
    input  bpu_pkg::addr_t       lookup_pc_i,
    input  bpu_pkg::ex_update_t  ex_upd_i,
    output bpu_pkg::target_rd_t  rd_o
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = bpu_pkg::XLEN - IDX_W - 2;  // word aligned index

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    tag_t                   tag_q    [BTB_ENTRIES];
    bpu_pkg::addr_t         target_q [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid_q;

    idx_t rd_idx;
    tag_t rd_tag;
    idx_t wr_idx;
    tag_t wr_tag;
    logic wr_en;

    assign rd_idx = lookup_pc_i[IDX_W+1:2];
    assign rd_tag = lookup_pc_i[bpu_pkg::XLEN-1:IDX_W+2];
    assign wr_idx = ex_upd_i.pc[IDX_W+1:2];
    assign wr_tag = ex_upd_i.pc[bpu_pkg::XLEN-1:IDX_W+2];
    assign wr_en  = ex_upd_i.valid && ex_upd_i.taken;  // only taken branches allocate

    assign rd_o.hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign rd_o.target = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= ex_upd_i.target;
        end
    end

    // valid bit and payload are written together
    assert property (@(posedge clk) disable iff (rst)
        rd_o.hit |-> !$isunknown(rd_o.target))
        else $error("btb hit with unknown target");

endmodule

// File: src/ras.sv
module ras #(
    parameter int RAS_DEPTH = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  bpu_pkg::ras_cmd_t   cmd_i,
    input  logic                flush_i,
    output bpu_pkg::target_rd_t top_o
);

    localparam int IDX_W = $clog2(RAS_DEPTH);
    localparam int PTR_W = IDX_W + 1;  // room for the full count

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [PTR_W-1:0] ptr_t;

    bpu_pkg::addr_t stack_q [RAS_DEPTH];
    ptr_t           sp_q;        // number of valid entries
    ptr_t           ckpt_sp_q;   // sp before the last push
    logic           ckpt_armed_q;

    ptr_t top_ptr;
    idx_t top_idx;
    logic empty;
    logic full;
    logic restore;
    logic swap;
    logic do_push;
    logic do_pop;
    logic wr_en;
    idx_t wr_idx;

    assign top_ptr = sp_q - ptr_t'(1);
    assign top_idx = top_ptr[IDX_W-1:0];
    assign empty   = (sp_q == '0);
    assign full    = (sp_q == ptr_t'(RAS_DEPTH));

    // priority: flush restore, push+pop, push, pop
    assign restore = flush_i && ckpt_armed_q;
    assign swap    = !restore && cmd_i.push && cmd_i.pop;
    assign do_push = !restore && cmd_i.push && !cmd_i.pop;
    assign do_pop  = !restore && cmd_i.pop && !cmd_i.push;

    assign wr_en  = (swap && !empty) || (do_push && !full);
    assign wr_idx = swap ? top_idx : sp_q[IDX_W-1:0];

    assign top_o.hit    = !empty;
    assign top_o.target = stack_q[top_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q         <= '0;
            ckpt_sp_q    <= '0;
            ckpt_armed_q <= 1'b0;
        end else if (restore) begin
            sp_q         <= ckpt_sp_q;
            ckpt_armed_q <= 1'b0;
        end else if (do_push) begin
            ckpt_sp_q    <= sp_q;
            ckpt_armed_q <= 1'b1;
            if (!full) begin
                sp_q <= sp_q + ptr_t'(1);
            end
        end else if (do_pop && !empty) begin
            sp_q <= top_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            stack_q[wr_idx] <= cmd_i.push_data;
        end
    end

    assert property (@(posedge clk) disable iff (rst) sp_q <= ptr_t'(RAS_DEPTH))
        else $error("ras sp above depth");

    // a restore must never land outside the stack either
    assert property (@(posedge clk) disable iff (rst)
        ckpt_armed_q |-> ckpt_sp_q <= ptr_t'(RAS_DEPTH))
        else $error("ras checkpoint above depth");

endmodule
